/* design/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
   input  wire logic                       clk,
   input  wire logic                       arstN,
   input  wire logic                       inValid,
   input  wire tinyPipePkg::ifId_t         in,
   input  wire logic                       wbValid,
   input  wire tinyPipePkg::retireRec_t    wb,
   input  wire logic                       exLoadValid,
   input  wire tinyPipePkg::regAddr_t      exLoadRd,
   output logic                            outValid,
   output tinyPipePkg::idEx_t              out,
   output logic                            stall,
   output logic                            haltSeen
);

   localparam int immWidth = tinyPipePkg::immWidth;
   localparam int dataWidth = tinyPipePkg::dataWidth;

   tinyPipePkg::word_t regFile [2**tinyPipePkg::regAddrWidth];
   tinyPipePkg::opcode_t op;
   tinyPipePkg::regAddr_t rd, rs, rt;
   logic regWrite, memRead, memWrite;
   logic usesRd, usesRs, usesRt;
   logic wbWrite;

   assign wbWrite = wbValid && wb.regWrite;

   // ==================================================
   // register file
   // ==================================================
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regFile <= '{default: '0};
      end else if (wbWrite) begin
         regFile[wb.writeRegister] <= wb.writeData;
      end
   end

   // a read in the writeback cycle sees the value being written.
   function automatic tinyPipePkg::word_t readReg(input tinyPipePkg::regAddr_t idx);
      if (wbWrite && wb.writeRegister == idx) begin
         return wb.writeData;
      end
      return regFile[idx];
   endfunction

   assign rd = in.inst[11:9];
   assign rs = in.inst[8:6];
   assign rt = in.inst[5:3];

   always_comb begin
      op       = tinyPipePkg::opNop;
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      usesRd   = 1'b0;
      usesRs   = 1'b0;
      usesRt   = 1'b0;
      case (in.inst[15:12])
         tinyPipePkg::opHalt: op = tinyPipePkg::opHalt;
         tinyPipePkg::opAdd, tinyPipePkg::opSub, tinyPipePkg::opAnd, tinyPipePkg::opXor: begin
            op       = tinyPipePkg::opcode_t'(in.inst[15:12]);
            regWrite = 1'b1;
            usesRs   = 1'b1;
            usesRt   = 1'b1;
         end
         tinyPipePkg::opAddi: begin
            op       = tinyPipePkg::opAddi;
            regWrite = 1'b1;
            usesRs   = 1'b1;
         end
         tinyPipePkg::opLd: begin
            op       = tinyPipePkg::opLd;
            regWrite = 1'b1;
            memRead  = 1'b1;
            usesRs   = 1'b1;
         end
         tinyPipePkg::opSt: begin
            op       = tinyPipePkg::opSt;
            memWrite = 1'b1;
            usesRs   = 1'b1;
            usesRd   = 1'b1; // rd holds the store data.
         end
         default: ;
      endcase
   end

   always_comb begin
      out.pc       = in.pc;
      out.inst     = in.inst;
      out.op       = op;
      out.rd       = rd;
      out.rs       = rs;
      out.rt       = rt;
      out.rdVal    = readReg(rd);
      out.rsVal    = readReg(rs);
      out.rtVal    = readReg(rt);
      out.imm      = {{(dataWidth-immWidth){in.inst[immWidth-1]}}, in.inst[immWidth-1:0]};
      out.regWrite = regWrite;
      out.memRead  = memRead;
      out.memWrite = memWrite;
      out.halt     = (op == tinyPipePkg::opHalt);
   end

   assign outValid = inValid;
   assign haltSeen = inValid && (op == tinyPipePkg::opHalt);

   // the load result is not ready until it reaches MEM/WB, so wait one cycle.
   assign stall = inValid && exLoadValid && ((usesRs && rs == exLoadRd) ||
                                             (usesRt && rt == exLoadRd) ||
                                             (usesRd && rd == exLoadRd));

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
   input  wire logic                       inValid,
   input  wire tinyPipePkg::idEx_t         in,
   input  wire logic                       memFwdValid,
   input  wire tinyPipePkg::exMem_t        memFwd,
   input  wire logic                       wbFwdValid,
   input  wire tinyPipePkg::retireRec_t    wbFwd,
   output tinyPipePkg::exMem_t             out
);

   tinyPipePkg::word_t rdVal, rsVal, rtVal;
   tinyPipePkg::word_t aluResult;

   // ==================================================
   // forwarding
   // ==================================================
   // the newest producer wins. A load never sits in EX/MEM here
   // with a consumer right behind it, because of the interlock.
   function automatic tinyPipePkg::word_t forward(input tinyPipePkg::regAddr_t idx,
                                                  input tinyPipePkg::word_t regVal);
      if (memFwdValid && memFwd.regWrite && memFwd.rd == idx) begin
         return memFwd.aluResult;
      end
      if (wbFwdValid && wbFwd.regWrite && wbFwd.writeRegister == idx) begin
         return wbFwd.writeData;
      end
      return regVal;
   endfunction

   assign rdVal = forward(in.rd, in.rdVal);
   assign rsVal = forward(in.rs, in.rsVal);
   assign rtVal = forward(in.rt, in.rtVal);

   // ==================================================
   // ALU
   // ==================================================
   always_comb begin
      case (in.op)
         tinyPipePkg::opAdd:  aluResult = rsVal + rtVal;
         tinyPipePkg::opSub:  aluResult = rsVal - rtVal;
         tinyPipePkg::opAnd:  aluResult = rsVal & rtVal;
         tinyPipePkg::opXor:  aluResult = rsVal ^ rtVal;
         tinyPipePkg::opAddi: aluResult = rsVal + in.imm;
         tinyPipePkg::opLd,
         tinyPipePkg::opSt:   aluResult = rsVal + in.imm; // effective address.
         default:             aluResult = '0;
      endcase
   end

   always_comb begin
      out.pc        = in.pc;
      out.inst      = in.inst;
      out.rd        = in.rd;
      out.aluResult = aluResult;
      out.storeData = rdVal;
      out.regWrite  = inValid && in.regWrite; // an empty slot must not forward.
      out.memRead   = inValid && in.memRead;
      out.memWrite  = inValid && in.memWrite;
      out.halt      = inValid && in.halt;
   end

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchStage #(
   parameter int imemDepth = 64
) (
   input  wire logic                          clk,
   input  wire logic                          arstN,
   input  wire logic                          start,
   input  wire logic                          stall,
   input  wire logic                          haltSeen,
   input  wire logic                          imemWrEn,
   input  wire logic [$clog2(imemDepth)-1:0]  imemWrAddr,
   input  wire tinyPipePkg::word_t            imemWrData,
   output logic                               fetchValid,
   output tinyPipePkg::ifId_t                 fetchOut
);

   localparam int imemAddrWidth = $clog2(imemDepth);

   tinyPipePkg::word_t imem [imemDepth];
   tinyPipePkg::word_t pc;
   logic running;

   // program load is only taken while the core sits idle.
   always_ff @(posedge clk) begin
      if (imemWrEn && !running) begin
         imem[imemWrAddr] <= imemWrData;
      end
   end

   // ==================================================
   // pc and run control
   // ==================================================
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         running <= 1'b0;
         pc      <= '0;
      end else if (start) begin
         running <= 1'b1;
         pc      <= '0;
      end else if (haltSeen) begin
         running <= 1'b0; // nothing past HALT is issued.
      end else if (running && !stall) begin
         pc <= pc + 1'b1;
      end
   end

   // the slot behind a HALT in decode goes out empty.
   assign fetchValid = running && !haltSeen;

   always_comb begin
      fetchOut.pc   = pc;
      fetchOut.inst = imem[pc[imemAddrWidth-1:0]];
   end

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/100ps
`default_nettype none

module memoryStage #(
   parameter int dmemDepth = 64
) (
   input  wire logic                    clk,
   input  wire logic                    inValid,
   input  wire tinyPipePkg::exMem_t     in,
   output tinyPipePkg::retireRec_t      out
);

   localparam int dmemAddrWidth = $clog2(dmemDepth);

   tinyPipePkg::word_t dmem [dmemDepth];
   tinyPipePkg::word_t loadData;
   logic [dmemAddrWidth-1:0] dmemAddr;

   assign dmemAddr = in.aluResult[dmemAddrWidth-1:0];

   // ==================================================
   // data memory
   // ==================================================
   always_ff @(posedge clk) begin
      if (inValid && in.memWrite) begin
         dmem[dmemAddr] <= in.storeData;
      end
   end

   assign loadData = dmem[dmemAddr]; // read is combinational.

   // ==================================================
   // retire record
   // ==================================================
   always_comb begin
      out.pc            = in.pc;
      out.inst          = in.inst;
      out.regWrite      = in.regWrite;
      out.writeRegister = in.rd;
      out.memRead       = in.memRead;
      out.memWrite      = in.memWrite;
      out.writeData     = '0;
      out.memAddress    = '0;
      out.memData       = '0;
      if (in.memRead) begin
         out.writeData  = loadData;
         out.memAddress = in.aluResult;
         out.memData    = loadData;
      end else if (in.memWrite) begin
         out.memAddress = in.aluResult;
         out.memData    = in.storeData;
      end else if (in.regWrite) begin
         out.writeData  = in.aluResult;
      end
   end

endmodule

`default_nettype wire

/* design/stageReg.sv */
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
   parameter type payload_t = logic
) (
   input  wire logic clk,
   input  wire logic arstN,
   input  wire logic hold,
   input  wire logic bubble,
   input  wire logic validIn,
   input  payload_t  dataIn,
   output logic      validOut,
   output payload_t  dataOut
);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validOut <= 1'b0;
      end else if (!hold) begin
         validOut <= validIn && !bubble; // a bubble leaves an empty slot behind.
      end
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         dataOut <= dataIn;
      end
   end

endmodule

`default_nettype wire

/* design/tinyPipe.sv */
`timescale 1ns/100ps
`default_nettype none

module tinyPipe #(
   parameter int imemDepth = 64,
   parameter int dmemDepth = 64
) (
   input  wire logic                          clk,
   input  wire logic                          arstN,
   input  wire logic                          start,
   input  wire logic                          imemWrEn,
   input  wire logic [$clog2(imemDepth)-1:0]  imemWrAddr,
   input  wire tinyPipePkg::word_t            imemWrData,
   output logic                               retireValid,
   output tinyPipePkg::retireRec_t            retire,
   output logic                               halted
);

   logic fetchValid, ifIdValid, decValid, idExValid, exMemValid;
   logic stall, haltSeen;
   tinyPipePkg::ifId_t       fetchOut, ifId;
   tinyPipePkg::idEx_t       decOut, idEx;
   tinyPipePkg::exMem_t      exOut, exMem;
   tinyPipePkg::retireRec_t  memOut;

   // ==================================================
   // fetch and decode
   // ==================================================
   fetchStage #(.imemDepth(imemDepth)) u_fetch (
      .clk(clk), .arstN(arstN), .start(start), .stall(stall), .haltSeen(haltSeen),
      .imemWrEn(imemWrEn), .imemWrAddr(imemWrAddr), .imemWrData(imemWrData),
      .fetchValid(fetchValid), .fetchOut(fetchOut));

   stageReg #(.payload_t(tinyPipePkg::ifId_t)) u_ifId (
      .clk(clk), .arstN(arstN), .hold(stall), .bubble(1'b0),
      .validIn(fetchValid), .dataIn(fetchOut), .validOut(ifIdValid), .dataOut(ifId));

   decodeStage u_decode (
      .clk(clk), .arstN(arstN), .inValid(ifIdValid), .in(ifId),
      .wbValid(retireValid), .wb(retire),
      .exLoadValid(idExValid && idEx.memRead), .exLoadRd(idEx.rd),
      .outValid(decValid), .out(decOut), .stall(stall), .haltSeen(haltSeen));

   stageReg #(.payload_t(tinyPipePkg::idEx_t)) u_idEx (
      .clk(clk), .arstN(arstN), .hold(1'b0), .bubble(stall),
      .validIn(decValid), .dataIn(decOut), .validOut(idExValid), .dataOut(idEx));

   // ==================================================
   // execute, memory and writeback
   // ==================================================
   executeStage u_execute (
      .inValid(idExValid), .in(idEx),
      .memFwdValid(exMemValid), .memFwd(exMem),
      .wbFwdValid(retireValid), .wbFwd(retire),
      .out(exOut));

   stageReg #(.payload_t(tinyPipePkg::exMem_t)) u_exMem (
      .clk(clk), .arstN(arstN), .hold(1'b0), .bubble(1'b0),
      .validIn(idExValid), .dataIn(exOut), .validOut(exMemValid), .dataOut(exMem));

   memoryStage #(.dmemDepth(dmemDepth)) u_memory (
      .clk(clk), .inValid(exMemValid), .in(exMem), .out(memOut));

   stageReg #(.payload_t(tinyPipePkg::retireRec_t)) u_memWb (
      .clk(clk), .arstN(arstN), .hold(1'b0), .bubble(1'b0),
      .validIn(exMemValid), .dataIn(memOut), .validOut(retireValid), .dataOut(retire));

   // set on the same edge that puts HALT into MEM/WB, so it rises as HALT retires.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
      end else if (exMemValid && exMem.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* design/tinyPipePkg.sv */
`default_nettype none

package tinyPipePkg;

   // ==================================================
   // widths
   // ==================================================
   localparam int dataWidth = 16;
   localparam int regAddrWidth = 3; // r0 is an ordinary register among the eight.
   localparam int immWidth = 6;

   typedef logic [dataWidth-1:0] word_t;
   typedef logic [regAddrWidth-1:0] regAddr_t;

   // codes not listed here decode as opNop.
   typedef enum logic [3:0] {
      opNop  = 4'h0,
      opHalt = 4'h1,
      opAdd  = 4'h2,
      opSub  = 4'h3,
      opAnd  = 4'h4,
      opXor  = 4'h5,
      opAddi = 4'h6,
      opLd   = 4'h7,
      opSt   = 4'h8
   } opcode_t;

   // ==================================================
   // stage payloads
   // ==================================================
   typedef struct packed {
      word_t pc;
      word_t inst;
   } ifId_t;

   typedef struct packed {
      word_t    pc;
      word_t    inst;
      opcode_t  op;
      regAddr_t rd;
      regAddr_t rs;
      regAddr_t rt;
      word_t    rdVal; // store data source for ST.
      word_t    rsVal;
      word_t    rtVal;
      word_t    imm; // already sign extended.
      logic     regWrite;
      logic     memRead;
      logic     memWrite;
      logic     halt;
   } idEx_t;

   typedef struct packed {
      word_t    pc;
      word_t    inst;
      regAddr_t rd;
      word_t    aluResult; // effective address for LD and ST.
      word_t    storeData;
      logic     regWrite;
      logic     memRead;
      logic     memWrite;
      logic     halt;
   } exMem_t;

   // also the MEM/WB payload.
   typedef struct packed {
      word_t    pc;
      word_t    inst;
      logic     regWrite;
      regAddr_t writeRegister;
      word_t    writeData;
      logic     memRead;
      logic     memWrite;
      word_t    memAddress;
      word_t    memData; // stored data for ST or loaded data for LD.
   } retireRec_t;

endpackage

`default_nettype wire

/* runSim.sh */
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and look for the pass line in sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f tinyPipe.f --top-module tinyPipeTb -o simTb > build.log 2>&1 \
   || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/simTb > sim.log 2>&1
cat sim.log

grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0 \
   || { echo "simulation failed, see sim.log"; exit 1; }

/* tests/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
   parameter int resetCycles = 16
) (
   output logic      clk,
   output logic      arstN,
   input  wire logic resetReq
);

   int resetCount = resetCycles;

   initial clk = 1'b0;
   initial arstN = 1'b0;

   always #2 clk = ~clk; // 4 ns period.

   always @(posedge clk) begin
      if (resetReq) begin
         resetCount <= resetCycles;
      end else if (resetCount > 0) begin
         resetCount <= resetCount - 1;
      end
   end

   always @(negedge clk) begin
      arstN <= (resetCount == 0); // reset edges land between rising edges.
   end

endmodule

`default_nettype wire

/* tests/tinyPipeTb.sv */
`timescale 1ns/100ps
`default_nettype none

module tinyPipeTb;

   localparam int imemDepth = 64;
   localparam int dmemDepth = 64;

   logic clk, arstN, resetReq, start, imemWrEn, retireValid, halted, collecting;
   logic [$clog2(imemDepth)-1:0] imemWrAddr;
   tinyPipePkg::word_t imemWrData;
   tinyPipePkg::retireRec_t retire;

   tinyPipePkg::word_t prog [$];
   tinyPipePkg::retireRec_t expQ [$];
   tinyPipePkg::retireRec_t gotQ [$];
   int errors = 0;
   int cycles = 0;
   int cycleLimit = 200; // grows by 40 cycles for each program instruction.
   integer seed;

   clockGen #(.resetCycles(16)) u_clockGen (.clk(clk), .arstN(arstN), .resetReq(resetReq));

   tinyPipe #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) u_tinyPipe (
      .clk(clk), .arstN(arstN), .start(start), .imemWrEn(imemWrEn),
      .imemWrAddr(imemWrAddr), .imemWrData(imemWrData),
      .retireValid(retireValid), .retire(retire), .halted(halted));

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (collecting && arstN && retireValid) begin
         gotQ.push_back(retire); // outputs are registered, so they are settled here.
      end
   end

   function automatic tinyPipePkg::word_t encR(input tinyPipePkg::opcode_t op,
                                               input int rd, input int rs, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   function automatic tinyPipePkg::word_t encI(input tinyPipePkg::opcode_t op,
                                               input int rd, input int rs, input int imm);
      return {op, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   // ==================================================
   // sequential instruction model
   // ==================================================
   task automatic buildExpected();
      tinyPipePkg::word_t regs [8];
      tinyPipePkg::word_t mem [dmemDepth];
      tinyPipePkg::retireRec_t rec;
      tinyPipePkg::word_t inst, imm, a, b, addr;
      expQ.delete();
      foreach (regs[i]) regs[i] = '0;
      foreach (mem[i]) mem[i] = '0;
      for (int pc = 0; pc < prog.size(); pc++) begin
         inst = prog[pc];
         imm  = {{10{inst[5]}}, inst[5:0]};
         a    = regs[inst[8:6]];
         b    = regs[inst[5:3]];
         addr = a + imm;
         rec  = '0;
         rec.pc   = 16'(pc);
         rec.inst = inst;
         rec.writeRegister = inst[11:9];
         rec.regWrite = inst[15:12] inside {tinyPipePkg::opAdd, tinyPipePkg::opSub,
                                            tinyPipePkg::opAnd, tinyPipePkg::opXor,
                                            tinyPipePkg::opAddi, tinyPipePkg::opLd};
         case (inst[15:12])
            tinyPipePkg::opAdd:  rec.writeData = a + b;
            tinyPipePkg::opSub:  rec.writeData = a - b;
            tinyPipePkg::opAnd:  rec.writeData = a & b;
            tinyPipePkg::opXor:  rec.writeData = a ^ b;
            tinyPipePkg::opAddi: rec.writeData = addr;
            tinyPipePkg::opLd: begin
               rec.memRead    = 1'b1;
               rec.memAddress = addr;
               rec.writeData  = mem[addr[5:0]];
               rec.memData    = mem[addr[5:0]];
            end
            tinyPipePkg::opSt: begin
               rec.memWrite     = 1'b1;
               rec.memAddress   = addr;
               rec.memData      = regs[inst[11:9]];
               mem[addr[5:0]]   = regs[inst[11:9]];
            end
            default: ; // HALT and every unused code leave the state alone.
         endcase
         if (rec.regWrite) regs[inst[11:9]] = rec.writeData;
         expQ.push_back(rec);
         if (inst[15:12] == tinyPipePkg::opHalt) break;
      end
   endtask

   // ==================================================
   // checking
   // ==================================================
   task automatic checkField(input string testName, input int idx, input string field,
                             input tinyPipePkg::word_t got, input tinyPipePkg::word_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s record %0d %s is %h, expected %h",
                  $time, testName, idx, field, got, exp);
         errors++;
      end
   endtask

   task automatic compareRecords(input string testName);
      int n;
      n = (gotQ.size() < expQ.size()) ? gotQ.size() : expQ.size();
      if (gotQ.size() != expQ.size()) begin
         $display("%s: expected %0d retire records but saw %0d",
                  testName, expQ.size(), gotQ.size());
         errors++;
      end
      for (int i = 0; i < n; i++) begin
         checkField(testName, i, "pc", gotQ[i].pc, expQ[i].pc);
         checkField(testName, i, "inst", gotQ[i].inst, expQ[i].inst);
         checkField(testName, i, "regWrite", 16'(gotQ[i].regWrite), 16'(expQ[i].regWrite));
         checkField(testName, i, "memRead", 16'(gotQ[i].memRead), 16'(expQ[i].memRead));
         checkField(testName, i, "memWrite", 16'(gotQ[i].memWrite), 16'(expQ[i].memWrite));
         if (expQ[i].regWrite) begin
            checkField(testName, i, "writeRegister", 16'(gotQ[i].writeRegister),
                       16'(expQ[i].writeRegister));
            checkField(testName, i, "writeData", gotQ[i].writeData, expQ[i].writeData);
         end
         if (expQ[i].memRead || expQ[i].memWrite) begin
            checkField(testName, i, "memAddress", gotQ[i].memAddress, expQ[i].memAddress);
            checkField(testName, i, "memData", gotQ[i].memData, expQ[i].memData);
         end
      end
   endtask

   // ==================================================
   // program runs
   // ==================================================
   task automatic pulseReset();
      @(negedge clk);
      resetReq = 1'b1;
      @(negedge clk);
      resetReq = 1'b0;
      @(posedge arstN);
   endtask

   task automatic loadProgram();
      for (int i = 0; i < prog.size(); i++) begin
         @(negedge clk);
         imemWrEn   = 1'b1;
         imemWrAddr = 6'(i);
         imemWrData = prog[i];
      end
      @(negedge clk);
      imemWrEn = 1'b0;
   endtask

   task automatic runProgram(input string testName);
      int waited;
      waited = 0;
      cycleLimit += 40 * prog.size();
      pulseReset();
      loadProgram();
      buildExpected();
      gotQ.delete();
      collecting = 1'b1;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (!halted && waited < 40 * prog.size()) begin
         @(negedge clk);
         waited++;
      end
      if (!halted) begin
         $display("%s: halted did not rise after %0d cycles", testName, waited);
         errors++;
      end
      repeat (8) @(negedge clk); // room for any record that should not appear.
      if (waited < 40 * prog.size() && !halted) begin
         $display("%s: halted fell again after HALT retired", testName);
         errors++;
      end
      collecting = 1'b0;
      compareRecords(testName);
   endtask

   task automatic aluChainTest();
      prog = '{encI(tinyPipePkg::opAddi, 1, 0, 13), encR(tinyPipePkg::opAdd, 2, 1, 1),
               encR(tinyPipePkg::opSub, 3, 2, 1), encR(tinyPipePkg::opAnd, 4, 3, 2),
               encR(tinyPipePkg::opXor, 5, 4, 3), encI(tinyPipePkg::opAddi, 6, 5, -7),
               encR(tinyPipePkg::opHalt, 0, 0, 0)};
      runProgram("alu chain");
   endtask

   task automatic loadUseTest();
      prog = '{encI(tinyPipePkg::opAddi, 1, 0, 9), encI(tinyPipePkg::opAddi, 2, 0, 20),
               encI(tinyPipePkg::opSt, 1, 0, 3), encI(tinyPipePkg::opLd, 3, 0, 3),
               encR(tinyPipePkg::opAdd, 4, 3, 2), encR(tinyPipePkg::opHalt, 0, 0, 0)};
      runProgram("load use");
   endtask

   task automatic storeLoadTest();
      prog = '{encI(tinyPipePkg::opAddi, 1, 0, -1), encI(tinyPipePkg::opAddi, 2, 0, 10),
               encI(tinyPipePkg::opSt, 1, 2, 5), encI(tinyPipePkg::opLd, 3, 2, 5),
               encI(tinyPipePkg::opSt, 2, 0, -2), encI(tinyPipePkg::opLd, 4, 0, -2),
               encR(tinyPipePkg::opHalt, 0, 0, 0)};
      runProgram("store load");
   endtask

   task automatic nopHaltTest();
      prog = '{16'h0000, 16'hc0ff, encI(tinyPipePkg::opAddi, 1, 0, 1), 16'h0000,
               encR(tinyPipePkg::opHalt, 0, 0, 0), encI(tinyPipePkg::opAddi, 2, 0, 2)};
      runProgram("nop halt");
   endtask

   task automatic randomAluTest();
      integer r;
      prog.delete();
      for (int i = 0; i < 30; i++) begin
         r = $random(seed);
         case ($unsigned(r[31:16]) % 5)
            0: prog.push_back({tinyPipePkg::opAdd, r[11:3], 3'b000});
            1: prog.push_back({tinyPipePkg::opSub, r[11:3], 3'b000});
            2: prog.push_back({tinyPipePkg::opAnd, r[11:3], 3'b000});
            3: prog.push_back({tinyPipePkg::opXor, r[11:3], 3'b000});
            default: prog.push_back({tinyPipePkg::opAddi, r[11:0]});
         endcase
      end
      prog.push_back(encR(tinyPipePkg::opHalt, 0, 0, 0));
      runProgram("random alu");
   endtask

   task automatic reloadTest();
      prog = '{encI(tinyPipePkg::opAddi, 1, 0, 7), encI(tinyPipePkg::opAddi, 2, 1, 7),
               encR(tinyPipePkg::opAdd, 3, 2, 1), encI(tinyPipePkg::opSt, 3, 0, 8),
               encI(tinyPipePkg::opLd, 4, 0, 8), encR(tinyPipePkg::opXor, 5, 4, 2),
               encR(tinyPipePkg::opSub, 6, 5, 3), encR(tinyPipePkg::opHalt, 0, 0, 0)};
      runProgram("reload first");
      prog = '{encI(tinyPipePkg::opAddi, 1, 0, 3), encI(tinyPipePkg::opAddi, 2, 1, 4),
               encR(tinyPipePkg::opHalt, 0, 0, 0)};
      runProgram("reload second");
   endtask

   initial begin
      resetReq   = 1'b0;
      start      = 1'b0;
      imemWrEn   = 1'b0;
      imemWrAddr = '0;
      imemWrData = '0;
      collecting = 1'b0;
      seed       = 32'hb7c;
      aluChainTest();
      loadUseTest();
      storeLoadTest();
      nopHaltTest();
      randomAluTest();
      reloadTest();
      $display("error count: %0d", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/tinyPipe_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module tinyPipe_assertions (
   input wire logic clk,
   input wire logic arstN,
   input wire logic retireValid,
   input wire logic halted
);

   // ==================================================
   // retire and halt rules
   // ==================================================
   noRetireAfterHalt: assert property (
      @(posedge clk) disable iff (!arstN) halted |=> !retireValid
   ) else $error("a record retired after the core had halted");

   haltedStaysHigh: assert property (
      @(posedge clk) disable iff (!arstN) halted |=> halted
   ) else $error("halted fell without a reset");

   quietInReset: assert property (
      @(posedge clk) !arstN |-> !retireValid
   ) else $error("retireValid was high during reset");

endmodule

bind tinyPipe tinyPipe_assertions u_assertions (
   .clk(clk),
   .arstN(arstN),
   .retireValid(retireValid),
   .halted(halted)
);

`default_nettype wire

/* tinyPipe.f */
design/tinyPipePkg.sv
design/stageReg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/tinyPipe.sv
tests/clockGen.sv
tests/tinyPipe_assertions.sv
tests/tinyPipeTb.sv
